// ==== Bender.yml ====
package:
  name: stage_id

sources:
  - src/RiscvPkg.sv
  - src/DecodeFieldsIf.sv
  - src/ControlIf.sv
  - src/InstDecoder.sv
  - src/Controller.sv
  - src/RegisterFile.sv
  - src/StageID.sv
  - target: test
    files:
      - tests/StageIdTb.sv

// ==== build.f ====
src/RiscvPkg.sv
src/DecodeFieldsIf.sv
src/ControlIf.sv
src/InstDecoder.sv
src/Controller.sv
src/RegisterFile.sv
src/StageID.sv
tests/StageIdTb.sv

// ==== src/ControlIf.sv ====
`timescale 1ns/1ps

// Control set for execute, memory and write-back
interface ControlIf import RiscvPkg::*; ();

    AluOp     aluOp;
    logic     regWrEnable;
    logic     memWrEnable;
    WbSel     wbSel;
    logic     operandASel;  // 1 takes the PC into ALU input A, AUIPC
    logic     operandBSel;  // 1 replaces rs2 by the immediate
    PcNextSel pcNextSel;

    modport src (
        output aluOp, regWrEnable, memWrEnable, wbSel,
        output operandASel, operandBSel, pcNextSel
    );

    modport sink (
        input aluOp, regWrEnable, memWrEnable, wbSel,
        input operandASel, operandBSel, pcNextSel
    );

endinterface

// ==== src/Controller.sv ====
`timescale 1ns/1ps

module Controller import RiscvPkg::*; (
    DecodeFieldsIf.ctrl fields,
    input  logic        i_IsEq,   // rs1 == rs2
    input  logic        i_IsLt,   // rs1 < rs2, signed
    input  logic        i_IsLtu,  // rs1 < rs2, unsigned
    ControlIf.src       ctrl
);

    AluOp arithOp;    // ALU op for the arithmetic groups
    logic branchHit;  // Branch condition from funct3

    // --------------------
    // Arithmetic op select
    // --------------------
    always_comb begin
        case (fields.funct3)
            // ADDI has no funct7, only register form can subtract
            3'b000:  arithOp = (fields.op == OpReg && fields.funct7[5]) ? AluSub : AluAdd;
            3'b001:  arithOp = AluSll;
            3'b010:  arithOp = AluSlt;
            3'b011:  arithOp = AluSltu;
            3'b100:  arithOp = AluXor;
            3'b101:  arithOp = fields.funct7[5] ? AluSra : AluSrl;  // SRA and SRAI alike
            3'b110:  arithOp = AluOr;
            default: arithOp = AluAnd;
        endcase
    end

    // Branch condition
    always_comb begin
        case (fields.funct3)
            3'b000:  branchHit = i_IsEq;    // BEQ
            3'b001:  branchHit = !i_IsEq;   // BNE
            3'b100:  branchHit = i_IsLt;    // BLT
            3'b101:  branchHit = !i_IsLt;   // BGE
            3'b110:  branchHit = i_IsLtu;   // BLTU
            3'b111:  branchHit = !i_IsLtu;  // BGEU
            default: branchHit = 1'b0;      // Reserved encodings never taken
        endcase
    end

    // --------------------
    // Control set
    // --------------------
    always_comb begin
        // Bubble unless an opcode below overrides
        ctrl.aluOp       = AluAdd;
        ctrl.regWrEnable = 1'b0;
        ctrl.memWrEnable = 1'b0;
        ctrl.wbSel       = WbSelAlu;
        ctrl.operandASel = 1'b0;
        ctrl.operandBSel = 1'b0;
        ctrl.pcNextSel   = PcSelSeq;

        case (fields.op)
            OpReg: begin
                ctrl.aluOp       = arithOp;
                ctrl.regWrEnable = 1'b1;
            end
            OpImm: begin
                ctrl.aluOp       = arithOp;
                ctrl.regWrEnable = 1'b1;
                ctrl.operandBSel = 1'b1;
            end
            OpLoad: begin
                ctrl.regWrEnable = 1'b1;  // Address is rs1+imm
                ctrl.wbSel       = WbSelMem;
                ctrl.operandBSel = 1'b1;
            end
            OpStore: begin
                ctrl.memWrEnable = 1'b1;
                ctrl.operandBSel = 1'b1;
            end
            OpBranch: begin
                ctrl.aluOp     = AluSub;
                ctrl.pcNextSel = branchHit ? PcSelRel : PcSelSeq;
            end
            OpJal: begin
                ctrl.regWrEnable = 1'b1;
                ctrl.wbSel       = WbSelLink;  // rd gets PC+4
                ctrl.pcNextSel   = PcSelRel;
            end
            OpJalr: begin
                ctrl.regWrEnable = 1'b1;
                ctrl.wbSel       = WbSelLink;
                ctrl.operandBSel = 1'b1;
                ctrl.pcNextSel   = PcSelReg;
            end
            OpLui: begin
                ctrl.aluOp       = AluCopyB;  // rd = U immediate
                ctrl.regWrEnable = 1'b1;
                ctrl.operandBSel = 1'b1;
            end
            OpAuipc: begin
                ctrl.regWrEnable = 1'b1;
                ctrl.operandASel = 1'b1;  // PC + U immediate
                ctrl.operandBSel = 1'b1;
            end
            default: ;  // Bubble
        endcase
    end

endmodule

// ==== src/DecodeFieldsIf.sv ====
`timescale 1ns/1ps

// Instruction fields from the decoder, plain levels while i_Inst is stable
interface DecodeFieldsIf import RiscvPkg::*; ();

    OpCode      op;
    RegAddr     rs1;
    RegAddr     rs2;
    RegAddr     rd;
    logic [2:0] funct3;
    logic [6:0] funct7;
    DataWord    imm;     // Sign-extended for the opcode's format

    modport src   (output op, rs1, rs2, rd, funct3, funct7, imm);
    modport ctrl  (input op, funct3, funct7);
    modport stage (input rs1, rs2, rd, imm);  // Register reads and operand B

endinterface

// ==== src/InstDecoder.sv ====
`timescale 1ns/1ps

module InstDecoder import RiscvPkg::*; (
    input  InstWord         i_Inst,  // Instruction from fetch
    DecodeFieldsIf.src      fields
);

    // --------------------
    // Fixed-position fields
    // --------------------
    assign fields.op     = i_Inst[6:0];
    assign fields.rd     = i_Inst[11:7];
    assign fields.funct3 = i_Inst[14:12];
    assign fields.rs1    = i_Inst[19:15];
    assign fields.rs2    = i_Inst[24:20];
    assign fields.funct7 = i_Inst[31:25];

    // --------------------
    // Immediate per format
    // --------------------
    always_comb begin
        case (i_Inst[6:0])
            // I format, shift amounts sit in the low five bits
            OpImm, OpLoad, OpJalr: begin
                fields.imm = {{20{i_Inst[31]}}, i_Inst[31:20]};
            end
            OpStore: begin  // S format, split across two fields
                fields.imm = {{20{i_Inst[31]}}, i_Inst[31:25], i_Inst[11:7]};
            end
            OpBranch: begin
                // B format, halfword offset
                fields.imm = {{19{i_Inst[31]}}, i_Inst[31], i_Inst[7],
                              i_Inst[30:25], i_Inst[11:8], 1'b0};
            end
            OpLui, OpAuipc: begin
                fields.imm = {i_Inst[31:12], 12'b0};  // U format, upper 20 bits
            end
            OpJal: begin
                // J format, 21-bit offset
                fields.imm = {{11{i_Inst[31]}}, i_Inst[31], i_Inst[19:12],
                              i_Inst[20], i_Inst[30:21], 1'b0};
            end
            default: begin
                fields.imm = '0;  // No immediate for unknown opcodes
            end
        endcase
    end

endmodule

// ==== src/RegisterFile.sv ====
`timescale 1ns/1ps

module RegisterFile import RiscvPkg::*; (
    input  logic    i_Clock,
    input  logic    i_rst,
    input  logic    i_WrEnable,  // Write strobe from write-back
    input  RegAddr  i_WrAddr,
    input  DataWord i_WrData,
    input  RegAddr  i_RdAddrA,   // rs1
    input  RegAddr  i_RdAddrB,   // rs2
    output DataWord o_RdDataA,
    output DataWord o_RdDataB
);

    DataWord regs [RegCount];

    // --------------------
    // Write port
    // --------------------
    always_ff @(posedge i_Clock) begin
        if (i_rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (i_WrEnable && i_WrAddr != '0) begin  // x0 writes dropped
            regs[i_WrAddr] <= i_WrData;
        end
    end

    // Asynchronous reads see new data only after the write edge
    // x0 keeps its reset zero because its writes are dropped
    assign o_RdDataA = regs[i_RdAddrA];
    assign o_RdDataB = regs[i_RdAddrB];

    // --------------------
    // Checks
    // --------------------
    // Index 0 reads zero on both ports
    assert property (@(posedge i_Clock) disable iff (i_rst)
        (i_RdAddrA != '0 || o_RdDataA == '0) && (i_RdAddrB != '0 || o_RdDataB == '0));

    // Write-back must present a known target
    assert property (@(posedge i_Clock) disable iff (i_rst)
        i_WrEnable |-> !$isunknown(i_WrAddr));

endmodule

// ==== src/RiscvPkg.sv ====
package RiscvPkg;

    // --------------------
    // Widths
    // --------------------
    localparam int DataWidth    = 32;  // XLEN for RV32I
    localparam int RegAddrWidth = 5;   // x0 to x31
    localparam int OpCodeWidth  = 7;
    localparam int RegCount     = 32;  // Architectural registers

    typedef logic [DataWidth-1:0]    DataWord;   // Register or operand value
    typedef logic [DataWidth-1:0]    PcWord;     // Instruction address
    typedef logic [DataWidth-1:0]    InstWord;   // Raw instruction
    typedef logic [RegAddrWidth-1:0] RegAddr;    // Register index
    typedef logic [OpCodeWidth-1:0]  OpCode;     // Major opcode, bits 6:0
    typedef logic [1:0]              PcNextSel;  // Next PC source
    typedef logic [1:0]              WbSel;      // Write-back source

    // --------------------
    // Major opcodes
    // --------------------
    localparam OpCode OpLui    = 7'b0110111;
    localparam OpCode OpAuipc  = 7'b0010111;
    localparam OpCode OpJal    = 7'b1101111;
    localparam OpCode OpJalr   = 7'b1100111;
    localparam OpCode OpBranch = 7'b1100011;
    localparam OpCode OpLoad   = 7'b0000011;
    localparam OpCode OpStore  = 7'b0100011;
    localparam OpCode OpImm    = 7'b0010011;  // Register-immediate arithmetic
    localparam OpCode OpReg    = 7'b0110011;  // Register-register arithmetic

    // Next PC selector values
    localparam PcNextSel PcSelSeq = 2'd0;  // PC+4
    localparam PcNextSel PcSelRel = 2'd1;  // PC+imm, branches and JAL
    localparam PcNextSel PcSelReg = 2'd2;  // rs1+imm with bit 0 cleared, JALR

    // Write-back selector values
    localparam WbSel WbSelAlu  = 2'd0;
    localparam WbSel WbSelMem  = 2'd1;  // Load data
    localparam WbSel WbSelLink = 2'd2;  // Return address PC+4

    // --------------------
    // ALU operations
    // --------------------
    typedef enum logic [3:0] {
        AluAdd,
        AluSub,
        AluSll,
        AluSlt,
        AluSltu,
        AluXor,
        AluSrl,
        AluSra,
        AluOr,
        AluAnd,
        AluCopyB   // Pass operand B through, LUI
    } AluOp;

endpackage

// ==== src/StageID.sv ====
`timescale 1ns/1ps

module StageID import RiscvPkg::*; (
    input  logic    i_Clock,
    input  logic    i_rst,

    // From fetch
    input  InstWord i_Inst,
    input  PcWord   i_PC,           // Address of i_Inst

    // Write-back from later stages
    input  RegAddr  i_RegWrAddr,
    input  DataWord i_RegWrData,
    input  logic    i_RegWrEnable,

    // To execute
    output OpCode   o_InstOP,
    output DataWord o_DataA,        // rs1
    output DataWord o_DataB,        // rs2 or immediate
    output DataWord o_MemWrData,    // Raw rs2 for stores
    output RegAddr  o_RegWrAddr,    // rd
    output logic    o_RegWrEnable,
    output logic    o_MemWrEnable,
    output WbSel    o_RegWrDataSel,
    output AluOp    o_AluControl,
    output logic    o_OperandASel,
    output PcWord   o_PCNext
);

    DecodeFieldsIf fieldsBus ();
    ControlIf      ctrlBus ();

    DataWord regDataA;
    DataWord regDataB;
    logic    isEq;
    logic    isLt;
    logic    isLtu;

    InstDecoder decoder (
        .i_Inst (i_Inst),
        .fields (fieldsBus.src)
    );

    Controller controller (
        .fields  (fieldsBus.ctrl),
        .i_IsEq  (isEq),
        .i_IsLt  (isLt),
        .i_IsLtu (isLtu),
        .ctrl    (ctrlBus.src)
    );

    // Write enable comes from write-back, not from this instruction
    RegisterFile regFile (
        .i_Clock    (i_Clock),
        .i_rst      (i_rst),
        .i_WrEnable (i_RegWrEnable),
        .i_WrAddr   (i_RegWrAddr),
        .i_WrData   (i_RegWrData),
        .i_RdAddrA  (fieldsBus.rs1),
        .i_RdAddrB  (fieldsBus.rs2),
        .o_RdDataA  (regDataA),
        .o_RdDataB  (regDataB)
    );

    // --------------------
    // Branch comparator
    // --------------------
    assign isEq  = (regDataA == regDataB);
    assign isLt  = ($signed(regDataA) < $signed(regDataB));
    assign isLtu = (regDataA < regDataB);

    // Next PC
    always_comb begin
        case (ctrlBus.pcNextSel)
            PcSelRel: o_PCNext = i_PC + fieldsBus.imm;
            PcSelReg: o_PCNext = (regDataA + fieldsBus.imm) & ~PcWord'(1);  // JALR target
            default:  o_PCNext = i_PC + PcWord'(4);
        endcase
    end

    assign o_DataB        = ctrlBus.operandBSel ? fieldsBus.imm : regDataB;
    assign o_DataA        = regDataA;
    assign o_MemWrData    = regDataB;
    assign o_InstOP       = fieldsBus.op;
    assign o_RegWrAddr    = fieldsBus.rd;
    assign o_RegWrEnable  = ctrlBus.regWrEnable;
    assign o_MemWrEnable  = ctrlBus.memWrEnable;
    assign o_RegWrDataSel = ctrlBus.wbSel;
    assign o_AluControl   = ctrlBus.aluOp;
    assign o_OperandASel  = ctrlBus.operandASel;

    // Selector encoding 3 is unused by the controller
    assert property (@(posedge i_Clock) disable iff (i_rst)
        ctrlBus.pcNextSel != 2'd3 && ctrlBus.wbSel != 2'd3);

endmodule

// ==== tests/StageIdTb.sv ====
`timescale 1ns/1ps

module StageIdTb import RiscvPkg::*; ();

    localparam int ClkPeriod = 20;

    logic    clock;
    logic    rst;
    InstWord inst;
    PcWord   pc;
    RegAddr  wbAddr;       // Write-back port
    DataWord wbData;
    logic    wbEnable;

    OpCode   instOp;
    DataWord dataA;
    DataWord dataB;
    DataWord memWrData;
    RegAddr  rdAddr;
    logic    regWrEnable;
    logic    memWrEnable;
    WbSel    wbSelOut;
    AluOp    aluControl;
    logic    operandASel;
    PcWord   pcNext;

    int vectorCount = 0;   // From the first line of the vector file
    int checkCount  = 0;
    int errorCount  = 0;

    StageID dut_i (
        .i_Clock (clock), .i_rst (rst), .i_Inst (inst), .i_PC (pc),
        .i_RegWrAddr (wbAddr), .i_RegWrData (wbData), .i_RegWrEnable (wbEnable),
        .o_InstOP (instOp), .o_DataA (dataA), .o_DataB (dataB),
        .o_MemWrData (memWrData), .o_RegWrAddr (rdAddr),
        .o_RegWrEnable (regWrEnable), .o_MemWrEnable (memWrEnable),
        .o_RegWrDataSel (wbSelOut), .o_AluControl (aluControl),
        .o_OperandASel (operandASel), .o_PCNext (pcNext)
    );

    initial begin
        clock = 1'b0;
        forever #(ClkPeriod/2) clock = ~clock;
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkData(input string name, input DataWord exp, input DataWord act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkPc(input string name, input PcWord exp, input PcWord act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkAlu(input string name, input AluOp exp, input AluOp act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic checkSel(input string name, input WbSel exp, input WbSel act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic checkAddr(input string name, input RegAddr exp, input RegAddr act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic checkOp(input string name, input OpCode exp, input OpCode act);
        checkCount++;
        if (act !== exp) begin
            errorCount++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // --------------------
    // Vector playback
    // --------------------
    initial begin
        int         fd;
        int         n;
        int         vectorsRun;
        string      line;
        string      kind;
        string      name;
        RegAddr     wAddr;
        DataWord    wData;
        InstWord    vInst;
        PcWord      vPc;
        DataWord    expA;
        DataWord    expB;
        DataWord    expMem;
        PcWord      expPc;
        logic [3:0] expAlu;   // Raw AluOp encoding
        logic       expRw;
        logic       expMw;
        logic       expASel;
        WbSel       expWb;
        RegAddr     expRd;

        rst        = 1'b1;
        inst       = '0;  // Illegal opcode decodes as a bubble
        pc         = 32'h0000_0100;
        wbAddr     = '0;
        wbData     = '0;
        wbEnable   = 1'b0;
        vectorsRun = 0;

        fd = $fopen("tests/StageIdVectors.txt", "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open tests/StageIdVectors.txt");
        end

        repeat (5) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        while (fd != 0 && $fgets(line, fd)) begin
            if (line.len() < 2 || line[0] == "#") continue;  // Comments and blanks
            n = $sscanf(line, "%s %s", kind, name);
            if (kind == "W") begin
                n = $sscanf(line, "%s %s %h %h", kind, name, wAddr, wData);
                if (n != 4) begin
                    errorCount++;
                    $display("Vector line for %s has missing columns", name);
                end
                @(negedge clock);
                wbAddr   = wAddr;
                wbData   = wData;
                wbEnable = 1'b1;   // One write strobe
                @(negedge clock);
                wbEnable = 1'b0;
                vectorsRun++;
            end else if (kind == "D") begin
                n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h",
                            kind, name, vInst, vPc, expA, expB, expMem, expPc,
                            expAlu, expRw, expMw, expWb, expASel, expRd);
                if (n != 14) begin
                    errorCount++;
                    $display("Vector line for %s has missing columns", name);
                end
                @(negedge clock);
                inst = vInst;
                pc   = vPc;
                #(ClkPeriod/2 - 1);  // Sample just before the rising edge
                checkOp({name, ".op"}, vInst[6:0], instOp);  // Major opcode field
                checkData({name, ".dataA"}, expA, dataA);
                checkData({name, ".dataB"}, expB, dataB);
                checkData({name, ".memWrData"}, expMem, memWrData);
                checkPc({name, ".pcNext"}, expPc, pcNext);
                checkAlu({name, ".aluOp"}, AluOp'(expAlu), aluControl);
                checkBit({name, ".regWrEnable"}, expRw, regWrEnable);
                checkBit({name, ".memWrEnable"}, expMw, memWrEnable);
                checkSel({name, ".wbSel"}, expWb, wbSelOut);
                checkBit({name, ".operandASel"}, expASel, operandASel);
                checkAddr({name, ".rd"}, expRd, rdAddr);
                vectorsRun++;
            end else begin
                vectorCount = kind.atoi();  // Header line
            end
        end

        if (vectorCount == 0 || vectorsRun != vectorCount) begin
            errorCount++;
            $display("Ran %0d vectors but the file header gives %0d", vectorsRun, vectorCount);
        end

        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog allows 3 cycles per vector plus reset margin
    initial begin
        wait (vectorCount > 0);
        #((vectorCount * 3 + 20) * ClkPeriod);
        $display("Timeout: the vectors did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== tests/StageIdVectors.txt ====
# W name addr data
# D name inst pc dataA dataB memWrData pcNext aluOp regWr memWr wbSel aSel rd (all hex)
23
D reset  00000000 00000100 00000000 00000000 00000000 00000104 0 0 0 0 0 00
W wrX1   01 00000005
W wrX2   02 FFFFFFFD
W wrX4   04 00001000
W wrX0   00 DEADBEEF
D add    002082B3 00000100 00000005 FFFFFFFD FFFFFFFD 00000104 0 1 0 0 0 05
D subX0  40100333 00000100 00000000 00000005 00000005 00000104 1 1 0 0 0 06
D sra    401153B3 00000100 FFFFFFFD 00000005 00000005 00000104 7 1 0 0 0 07
D sltu   0020B433 00000100 00000005 FFFFFFFD FFFFFFFD 00000104 4 1 0 0 0 08
D addi   FFF08493 00000100 00000005 FFFFFFFF 00000000 00000104 0 1 0 0 0 09
D srai   40115513 00000100 FFFFFFFD 00000401 00000005 00000104 7 1 0 0 0 0A
D lw     00822583 00000100 00001000 00000008 00000000 00000104 0 1 0 1 0 0B
D sw     FE122E23 00000100 00001000 FFFFFFFC 00000005 00000104 0 0 1 0 0 1C
D beqT   00108863 00000100 00000005 00000005 00000005 00000110 1 0 0 0 0 10
D bneN   00109863 00000100 00000005 00000005 00000005 00000104 1 0 0 0 0 10
D bltT   FE114CE3 00000100 FFFFFFFD 00000005 00000005 000000F8 1 0 0 0 0 19
D bltuN  FE116CE3 00000100 FFFFFFFD 00000005 00000005 00000104 1 0 0 0 0 19
D bgeT   0020D863 00000100 00000005 FFFFFFFD FFFFFFFD 00000110 1 0 0 0 0 10
D bgeuN  0020F863 00000100 00000005 FFFFFFFD FFFFFFFD 00000104 1 0 0 0 0 10
D jal    020000EF 00000100 00000000 00000000 00000000 00000120 0 1 0 2 0 01
D jalr   00320067 00000100 00001000 00000003 00000000 00001002 0 1 0 2 0 00
D lui    ABCDE637 00000100 00000000 ABCDE000 00000000 00000104 A 1 0 0 0 0C
D auipc  00001697 00000100 00000000 00001000 00000000 00000104 0 1 0 0 1 0D
